// ==== logic/elevator_settings.svh ====
`ifndef ELEVATOR_SETTINGS_SVH
`define ELEVATOR_SETTINGS_SVH

// floors served, numbered from 0 at the bottom
`define ELEV_FLOORS 8

// width of a floor index
`define ELEV_FLOOR_BITS 3

// door open time in clock cycles, short for simulation
`define ELEV_DWELL_CYCLES 40

// dwell counter width, must hold ELEV_DWELL_CYCLES
`define ELEV_TIMER_BITS 8

`endif

// ==== logic/elevator_pkg.sv ====
`include "elevator_settings.svh"

package elevator_pkg;

	typedef logic [`ELEV_FLOOR_BITS-1:0] floor_t;
	typedef logic [`ELEV_FLOORS-1:0] floor_mask_t; // one bit per floor

	// button levels in, lamps out
	typedef struct packed {
		floor_mask_t car;
		floor_mask_t hall_up;
		floor_mask_t hall_down;
	} call_set_t;

	typedef enum logic [1:0] {
		MOTOR_STOP = 2'd0,
		MOTOR_DOWN = 2'd1,
		MOTOR_UP   = 2'd2
	} motor_cmd_e;

	typedef enum logic [1:0] {
		DOOR_IDLE  = 2'd0,
		DOOR_OPEN  = 2'd1,
		DOOR_CLOSE = 2'd2
	} door_cmd_e;

	typedef enum logic [1:0] {
		SENSOR_BETWEEN = 2'd0,
		SENSOR_OPENED  = 2'd1,
		SENSOR_CLOSED  = 2'd2
	} door_sensor_e;

	typedef struct packed {
		logic open_btn;
		logic close_btn;
		logic obstructed; // light curtain covered
		logic overload;
	} cabin_inputs_t;

	typedef enum logic [1:0] {SCHED_IDLE, SCHED_MOVING, SCHED_DOOR_CYCLE} sched_state_e;

	typedef enum logic [1:0] {DOOR_SHUT, DOOR_OPENING, DOOR_DWELL, DOOR_CLOSING} door_state_e;

endpackage

// ==== logic/call_register.sv ====
`timescale 1ns/1ps
`include "elevator_settings.svh"

module call_register (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  elevator_pkg::call_set_t i_buttons,
	input  logic                    i_serve,
	input  elevator_pkg::floor_t    i_serve_floor,
	input  logic                    i_serve_dir,
	input  logic                    i_serve_reverse,
	output elevator_pkg::call_set_t o_calls
);

	// no hall up call at the top floor, no hall down call at the bottom
	localparam elevator_pkg::floor_mask_t UP_VALID =
		~(elevator_pkg::floor_mask_t'(1) << (`ELEV_FLOORS - 1));
	localparam elevator_pkg::floor_mask_t DOWN_VALID = ~elevator_pkg::floor_mask_t'(1);

	elevator_pkg::floor_mask_t serve_onehot;
	elevator_pkg::call_set_t   clear_set;
	elevator_pkg::call_set_t   press_set;
	elevator_pkg::call_set_t   next_calls;

	assign serve_onehot = i_serve ? (elevator_pkg::floor_mask_t'(1) << i_serve_floor) : '0;

	always_comb begin
		clear_set.car = serve_onehot;
		// hall calls clear by departing direction, both on a reversal
		clear_set.hall_up   = (i_serve_dir | i_serve_reverse) ? serve_onehot : '0;
		clear_set.hall_down = (~i_serve_dir | i_serve_reverse) ? serve_onehot : '0;
	end

	always_comb begin
		press_set.car       = i_buttons.car;
		press_set.hall_up   = i_buttons.hall_up & UP_VALID;
		press_set.hall_down = i_buttons.hall_down & DOWN_VALID;
	end

	// a press on the clearing cycle keeps the lamp on
	assign next_calls = (o_calls & ~clear_set) | press_set;

	always_ff @(posedge i_clock or negedge i_reset) begin
		if (!i_reset) begin
			o_calls <= '0;
		end else begin
			o_calls <= next_calls;
		end
	end

endmodule

// ==== logic/travel_scheduler.sv ====
`timescale 1ns/1ps
`include "elevator_settings.svh"

module travel_scheduler (
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  elevator_pkg::call_set_t  i_calls,
	input  logic                     i_floor_reached,
	input  logic                     i_door_done,
	output elevator_pkg::motor_cmd_e o_motor,
	output logic                     o_direction,
	output elevator_pkg::floor_t     o_floor,
	output logic                     o_serve,
	output elevator_pkg::floor_t     o_serve_floor,
	output logic                     o_serve_dir,
	output logic                     o_serve_reverse,
	output logic                     o_door_start
);

	elevator_pkg::sched_state_e state;
	elevator_pkg::floor_t       step_floor;
	elevator_pkg::floor_t       probe_floor;
	elevator_pkg::floor_mask_t  above_mask;
	elevator_pkg::floor_mask_t  below_mask;
	elevator_pkg::floor_mask_t  any_call;
	logic                       calls_above;
	logic                       calls_below;
	logic                       ahead;
	logic                       behind;
	logic                       here_dir;
	logic                       here_opp;
	logic                       serve_here;
	logic                       stop_at;
	logic                       depart_dir;

	assign step_floor = o_direction ? o_floor + 1'b1 : o_floor - 1'b1; // level being approached

	// while moving, the rule looks at the floor about to be reached
	assign probe_floor = (state == elevator_pkg::SCHED_MOVING) ? step_floor : o_floor;

	always_comb begin
		above_mask = '0;
		below_mask = '0;
		for (int i = 0; i < `ELEV_FLOORS; i++) begin
			above_mask[i] = (i > int'(probe_floor));
			below_mask[i] = (i < int'(probe_floor));
		end
	end

	assign any_call    = i_calls.car | i_calls.hall_up | i_calls.hall_down;
	assign calls_above = |(any_call & above_mask);
	assign calls_below = |(any_call & below_mask);

	assign ahead  = o_direction ? calls_above : calls_below;
	assign behind = o_direction ? calls_below : calls_above;

	assign here_dir = i_calls.car[probe_floor] |
		(o_direction ? i_calls.hall_up[probe_floor] : i_calls.hall_down[probe_floor]);
	assign here_opp = o_direction ? i_calls.hall_down[probe_floor] : i_calls.hall_up[probe_floor];

	// collective rule: own direction, or opposite hall call with nothing beyond
	assign serve_here = here_dir | (here_opp & ~ahead);
	assign stop_at    = serve_here | ~ahead; // end of run always stops
	assign depart_dir = ahead ? o_direction : ~o_direction;

	always_ff @(posedge i_clock or negedge i_reset) begin
		if (!i_reset) begin
			state        <= elevator_pkg::SCHED_IDLE;
			o_motor      <= elevator_pkg::MOTOR_STOP;
			o_direction  <= 1'b0;
			o_floor      <= '0; // parked at the bottom
			o_serve      <= 1'b0;
			o_door_start <= 1'b0;
		end else begin
			o_serve      <= 1'b0;
			o_door_start <= 1'b0;
			case (state)
				elevator_pkg::SCHED_IDLE: begin
					if (serve_here) begin
						o_serve      <= 1'b1;
						o_door_start <= 1'b1;
						o_direction  <= depart_dir;
						state        <= elevator_pkg::SCHED_DOOR_CYCLE;
					end else if (ahead) begin
						o_motor <= o_direction ? elevator_pkg::MOTOR_UP : elevator_pkg::MOTOR_DOWN;
						state   <= elevator_pkg::SCHED_MOVING;
					end else if (behind) begin
						o_direction <= ~o_direction;
						o_motor     <= o_direction ? elevator_pkg::MOTOR_DOWN : elevator_pkg::MOTOR_UP;
						state       <= elevator_pkg::SCHED_MOVING;
					end
				end
				elevator_pkg::SCHED_MOVING: begin
					if (i_floor_reached) begin
						o_floor <= step_floor;
						if (stop_at) begin
							o_motor      <= elevator_pkg::MOTOR_STOP;
							o_serve      <= 1'b1;
							o_door_start <= 1'b1;
							o_direction  <= depart_dir; // flips when nothing lies beyond
							state        <= elevator_pkg::SCHED_DOOR_CYCLE;
						end
					end
				end
				elevator_pkg::SCHED_DOOR_CYCLE: begin
					if (i_door_done) begin
						state <= elevator_pkg::SCHED_IDLE; // idle re-evaluates next cycle
					end
				end
				default: begin
					state   <= elevator_pkg::SCHED_IDLE;
					o_motor <= elevator_pkg::MOTOR_STOP;
				end
			endcase
		end
	end

	// service details, qualified by o_serve
	always_ff @(posedge i_clock) begin
		o_serve_floor   <= probe_floor;
		o_serve_dir     <= depart_dir;
		o_serve_reverse <= ~ahead;
	end

endmodule

// ==== logic/door_controller.sv ====
`timescale 1ns/1ps
`include "elevator_settings.svh"

module door_controller (
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  logic                        i_door_start,
	input  elevator_pkg::door_sensor_e  i_door_sensor,
	input  elevator_pkg::cabin_inputs_t i_cabin,
	output elevator_pkg::door_cmd_e     o_door,
	output logic                        o_door_done
);

	localparam int unsigned DWELL_LAST = `ELEV_DWELL_CYCLES - 1;

	elevator_pkg::door_state_e   state;
	logic [`ELEV_TIMER_BITS-1:0] dwell_count;
	logic                        reopen;
	logic                        dwell_over;

	// anything in the doorway, too much weight, or a passenger asking
	assign reopen = i_cabin.obstructed | i_cabin.overload | i_cabin.open_btn;

	assign dwell_over = i_cabin.close_btn | (dwell_count == DWELL_LAST[`ELEV_TIMER_BITS-1:0]);

	always_ff @(posedge i_clock or negedge i_reset) begin
		if (!i_reset) begin
			state       <= elevator_pkg::DOOR_SHUT;
			dwell_count <= '0;
			o_door_done <= 1'b0;
		end else begin
			o_door_done <= 1'b0;
			case (state)
				elevator_pkg::DOOR_SHUT: begin
					if (i_door_start) begin
						state <= elevator_pkg::DOOR_OPENING;
					end
				end
				elevator_pkg::DOOR_OPENING: begin
					if (i_door_sensor == elevator_pkg::SENSOR_OPENED) begin
						state       <= elevator_pkg::DOOR_DWELL;
						dwell_count <= '0; // restarts after every reopen
					end
				end
				elevator_pkg::DOOR_DWELL: begin
					if (dwell_over) begin
						state <= elevator_pkg::DOOR_CLOSING;
					end else begin
						dwell_count <= dwell_count + 1'b1;
					end
				end
				elevator_pkg::DOOR_CLOSING: begin
					if (reopen) begin
						state <= elevator_pkg::DOOR_OPENING;
					end else if (i_door_sensor == elevator_pkg::SENSOR_CLOSED) begin
						state       <= elevator_pkg::DOOR_SHUT;
						o_door_done <= 1'b1;
					end
				end
				default: begin
					state <= elevator_pkg::DOOR_SHUT;
				end
			endcase
		end
	end

	// door drive follows the state, idle while shut or held open
	always_comb begin
		case (state)
			elevator_pkg::DOOR_OPENING: o_door = elevator_pkg::DOOR_OPEN;
			elevator_pkg::DOOR_CLOSING: o_door = elevator_pkg::DOOR_CLOSE;
			default:                    o_door = elevator_pkg::DOOR_IDLE;
		endcase
	end

endmodule

// ==== logic/elevator_top.sv ====
`timescale 1ns/1ps

module elevator_top (
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  elevator_pkg::call_set_t     i_buttons,
	input  logic                        i_floor_reached, // one pulse per level
	input  elevator_pkg::door_sensor_e  i_door_sensor,
	input  elevator_pkg::cabin_inputs_t i_cabin,
	output elevator_pkg::motor_cmd_e    o_motor,
	output elevator_pkg::door_cmd_e     o_door,
	output logic                        o_direction, // 1 is up
	output elevator_pkg::floor_t        o_floor,
	output elevator_pkg::call_set_t     o_call_lamps
);

	logic                 serve;
	elevator_pkg::floor_t serve_floor;
	logic                 serve_dir;
	logic                 serve_reverse;
	logic                 door_start;
	logic                 door_done;

	call_register u_call_register (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_buttons       (i_buttons),
		.i_serve         (serve),
		.i_serve_floor   (serve_floor),
		.i_serve_dir     (serve_dir),
		.i_serve_reverse (serve_reverse),
		.o_calls         (o_call_lamps)
	);

	travel_scheduler u_travel_scheduler (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_calls         (o_call_lamps),
		.i_floor_reached (i_floor_reached),
		.i_door_done     (door_done),
		.o_motor         (o_motor),
		.o_direction     (o_direction),
		.o_floor         (o_floor),
		.o_serve         (serve),
		.o_serve_floor   (serve_floor),
		.o_serve_dir     (serve_dir),
		.o_serve_reverse (serve_reverse),
		.o_door_start    (door_start)
	);

	door_controller u_door_controller (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_door_start  (door_start),
		.i_door_sensor (i_door_sensor),
		.i_cabin       (i_cabin),
		.o_door        (o_door),
		.o_door_done   (door_done)
	);

endmodule

// ==== verification/elevator_asserts.sv ====
`timescale 1ns/1ps

module elevator_asserts (
	input logic                       i_clock,
	input logic                       i_reset,
	input logic                       i_floor_reached,
	input elevator_pkg::door_sensor_e i_door_sensor,
	input elevator_pkg::motor_cmd_e   i_motor,
	input elevator_pkg::door_cmd_e    i_door,
	input elevator_pkg::floor_t       i_floor
);

	int error_count = 0;

	// car runs only with the door shut and not driven
	motor_needs_shut_door: assert property (@(posedge i_clock) disable iff (!i_reset)
		i_motor != elevator_pkg::MOTOR_STOP |->
			(i_door_sensor == elevator_pkg::SENSOR_CLOSED && i_door == elevator_pkg::DOOR_IDLE))
	else begin
		error_count++;
		$error("motor running while the door is not shut");
	end

	no_open_in_motion: assert property (@(posedge i_clock) disable iff (!i_reset)
		i_door == elevator_pkg::DOOR_OPEN |-> i_motor == elevator_pkg::MOTOR_STOP)
	else begin
		error_count++;
		$error("door driven open while the motor runs");
	end

	floor_moves_on_pulse: assert property (@(posedge i_clock) disable iff (!i_reset)
		i_floor != $past(i_floor) |-> $past(i_floor_reached))
	else begin
		error_count++;
		$error("floor display changed without a floor-reached pulse");
	end

endmodule

bind elevator_top elevator_asserts u_elevator_asserts (
	.i_clock         (i_clock),
	.i_reset         (i_reset),
	.i_floor_reached (i_floor_reached),
	.i_door_sensor   (i_door_sensor),
	.i_motor         (o_motor),
	.i_door          (o_door),
	.i_floor         (o_floor)
);

// ==== verification/elevator_tb.sv ====
`timescale 1ns/1ps
`include "elevator_settings.svh"

module elevator_tb;

	localparam int RANDOM_CYCLES = 6000;
	localparam int DRAIN_TIMEOUT = 30000;

	logic                        clock;
	logic                        reset;
	elevator_pkg::call_set_t     buttons;
	logic                        floor_reached;
	elevator_pkg::door_sensor_e  door_sensor;
	elevator_pkg::cabin_inputs_t cabin;
	elevator_pkg::motor_cmd_e    motor;
	elevator_pkg::door_cmd_e     door;
	logic                        direction;
	elevator_pkg::floor_t        floor_shown;
	elevator_pkg::call_set_t     lamps;

	int unsigned seed = 64851;
	logic        stimulus_on;
	int          shaft_cnt = 0;
	int          door_cnt = 0;
	elevator_pkg::door_cmd_e door_last = elevator_pkg::DOOR_IDLE;

	// reference model of the car, values expected after the last edge
	elevator_pkg::sched_state_e m_state;
	elevator_pkg::call_set_t    m_calls;
	elevator_pkg::call_set_t    pend_clear;
	elevator_pkg::floor_t       m_floor;
	logic                       m_dir;
	elevator_pkg::motor_cmd_e   m_motor;
	logic                       closing_seen;
	logic                       close_cut;
	int                         dwell_cnt;
	int                         door_wait; // edges until door_want is due
	elevator_pkg::door_cmd_e    door_want;

	elevator_top u_elevator_top (
		.i_clock         (clock),
		.i_reset         (reset),
		.i_buttons       (buttons),
		.i_floor_reached (floor_reached),
		.i_door_sensor   (door_sensor),
		.i_cabin         (cabin),
		.o_motor         (motor),
		.o_door          (door),
		.o_direction     (direction),
		.o_floor         (floor_shown),
		.o_call_lamps    (lamps)
	);

	always #2 clock = ~clock;

	function automatic int unsigned next_random();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed >> 16;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, want);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	function automatic logic calls_beyond(elevator_pkg::call_set_t c, int f, logic up);
		elevator_pkg::floor_mask_t any;
		any = c.car | c.hall_up | c.hall_down;
		for (int i = 0; i < `ELEV_FLOORS; i++) begin
			if (any[i] && (up ? i > f : i < f))
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// collective rule, own direction or a last opposite hall call
	function automatic logic stop_wanted(elevator_pkg::call_set_t c, int f, logic up);
		logic with_dir;
		logic against;
		with_dir = c.car[f] | (up ? c.hall_up[f] : c.hall_down[f]);
		against  = up ? c.hall_down[f] : c.hall_up[f];
		return with_dir | (against & ~calls_beyond(c, f, up));
	endfunction

	task automatic record_stop(input int f);
		logic onward;
		onward = calls_beyond(m_calls, f, m_dir);
		pend_clear = '0;
		pend_clear.car[f]       = 1'b1;
		pend_clear.hall_up[f]   = m_dir | ~onward; // turning around clears both
		pend_clear.hall_down[f] = ~m_dir | ~onward;
		if (!onward)
			m_dir = ~m_dir;
		m_motor      = elevator_pkg::MOTOR_STOP;
		m_state      = elevator_pkg::SCHED_DOOR_CYCLE;
		closing_seen = 1'b0;
		door_want    = elevator_pkg::DOOR_OPEN;
		door_wait    = 2;
	endtask

	always @(posedge clock) begin : passengers
		int unsigned r;
		int unsigned s;
		elevator_pkg::cabin_inputs_t press;
		r = next_random();
		s = next_random();
		press = '0;
		buttons <= '0;
		if (stimulus_on) begin
			if (r % 32 == 0)
				buttons <= elevator_pkg::call_set_t'(24'd1 << ((r >> 5) % 24));
			if (door == elevator_pkg::DOOR_CLOSE && s % 8 == 0) begin
				case ((s >> 3) % 3)
					0: press.obstructed = 1'b1;
					1: press.overload   = 1'b1;
					default: press.open_btn = 1'b1;
				endcase
			end
			if (door == elevator_pkg::DOOR_IDLE && door_sensor == elevator_pkg::SENSOR_OPENED &&
					(s >> 5) % 32 == 0)
				press.close_btn = 1'b1;
		end
		cabin <= press;
	end

	// one level every 12 cycles of motion
	always @(posedge clock) begin : shaft
		if (motor == elevator_pkg::MOTOR_STOP) begin
			shaft_cnt     <= 0;
			floor_reached <= 1'b0;
		end else begin
			shaft_cnt     <= (shaft_cnt == 11) ? 0 : shaft_cnt + 1;
			floor_reached <= (shaft_cnt == 11);
		end
	end

	always @(posedge clock) begin : door_mechanics
		if (door == elevator_pkg::DOOR_IDLE || door != door_last)
			door_cnt = 0;
		else
			door_cnt++;
		door_last = door;
		if (door == elevator_pkg::DOOR_OPEN)
			door_sensor <= (door_cnt >= 5) ? elevator_pkg::SENSOR_OPENED : elevator_pkg::SENSOR_BETWEEN;
		else if (door == elevator_pkg::DOOR_CLOSE)
			door_sensor <= (door_cnt >= 5) ? elevator_pkg::SENSOR_CLOSED : elevator_pkg::SENSOR_BETWEEN;
	end

	always @(posedge clock) begin : model
		elevator_pkg::call_set_t pressed;
		elevator_pkg::call_set_t next_calls;
		if (reset) begin
			check_value("o_call_lamps", lamps, m_calls);
			check_value("o_floor", floor_shown, m_floor);
			check_value("o_direction", direction, m_dir);
			check_value("o_motor", motor, m_motor);
			if (door_wait == 1)
				check_value("o_door", door, door_want);
			if (door_wait > 0)
				door_wait--;
			pressed = buttons;
			pressed.hall_up[`ELEV_FLOORS-1] = 1'b0; // no up call from the top
			pressed.hall_down[0]            = 1'b0;
			next_calls = (m_calls & ~pend_clear) | pressed;
			pend_clear = '0;
			case (m_state)
				elevator_pkg::SCHED_IDLE: begin
					if (stop_wanted(m_calls, m_floor, m_dir)) begin
						record_stop(m_floor);
					end else if (calls_beyond(m_calls, m_floor, m_dir)) begin
						m_motor = m_dir ? elevator_pkg::MOTOR_UP : elevator_pkg::MOTOR_DOWN;
						m_state = elevator_pkg::SCHED_MOVING;
					end else if (calls_beyond(m_calls, m_floor, ~m_dir)) begin
						m_dir   = ~m_dir;
						m_motor = m_dir ? elevator_pkg::MOTOR_UP : elevator_pkg::MOTOR_DOWN;
						m_state = elevator_pkg::SCHED_MOVING;
					end
				end
				elevator_pkg::SCHED_MOVING: begin
					if (floor_reached) begin
						m_floor = m_dir ? m_floor + 1'b1 : m_floor - 1'b1;
						if (stop_wanted(m_calls, m_floor, m_dir))
							record_stop(m_floor);
					end
				end
				default: begin
					if (closing_seen && door == elevator_pkg::DOOR_IDLE &&
							door_sensor == elevator_pkg::SENSOR_CLOSED)
						m_state = elevator_pkg::SCHED_IDLE;
				end
			endcase
			m_calls = next_calls;
			if (door == elevator_pkg::DOOR_CLOSE) begin
				closing_seen = 1'b1;
				if (cabin.obstructed | cabin.overload | cabin.open_btn) begin
					door_want = elevator_pkg::DOOR_OPEN; // reopen on the next cycle
					door_wait = 1;
				end
			end
			if (door == elevator_pkg::DOOR_IDLE && door_sensor == elevator_pkg::SENSOR_OPENED) begin
				dwell_cnt++;
				if (cabin.close_btn) begin
					close_cut = 1'b1;
					door_want = elevator_pkg::DOOR_CLOSE;
					door_wait = 1;
				end
			end else if (door == elevator_pkg::DOOR_CLOSE && dwell_cnt != 0) begin
				if (!close_cut)
					check_value("dwell cycles", dwell_cnt, `ELEV_DWELL_CYCLES);
				dwell_cnt = 0;
				close_cut = 1'b0;
			end
		end
	end

	always @(negedge clock) begin
		if (u_elevator_top.u_elevator_asserts.error_count != 0) begin
			$display("a bound assertion on elevator_top failed");
			$display("Verification failed");
			$fatal(1);
		end
	end

	initial begin
		int wait_cycles;
		clock         = 1'b0;
		reset         = 1'b0;
		buttons       = '0;
		floor_reached = 1'b0;
		door_sensor   = elevator_pkg::SENSOR_CLOSED; // parked with the door shut
		cabin         = '0;
		stimulus_on   = 1'b0;
		m_state       = elevator_pkg::SCHED_IDLE;
		m_calls       = '0;
		pend_clear    = '0;
		m_floor       = '0;
		m_dir         = 1'b0;
		m_motor       = elevator_pkg::MOTOR_STOP;
		closing_seen  = 1'b0;
		close_cut     = 1'b0;
		dwell_cnt     = 0;
		door_wait     = 0;
		door_want     = elevator_pkg::DOOR_IDLE;
		repeat (5) @(posedge clock);
		reset <= 1'b1;
		@(negedge clock);
		check_value("o_motor", motor, elevator_pkg::MOTOR_STOP);
		check_value("o_door", door, elevator_pkg::DOOR_IDLE);
		check_value("o_floor", floor_shown, 0);
		check_value("o_call_lamps", lamps, 0);
		stimulus_on = 1'b1;
		repeat (RANDOM_CYCLES) @(negedge clock);
		stimulus_on = 1'b0;
		repeat (2) @(negedge clock); // last press reaches the lamps
		wait_cycles = 0;
		while (!(lamps == '0 && motor == elevator_pkg::MOTOR_STOP &&
				door == elevator_pkg::DOOR_IDLE && door_sensor == elevator_pkg::SENSOR_CLOSED &&
				m_state == elevator_pkg::SCHED_IDLE)) begin
			if (wait_cycles == DRAIN_TIMEOUT) begin
				$display("timeout: the car did not serve all calls and park with the door shut");
				$display("Verification failed");
				$fatal(1);
			end
			wait_cycles++;
			@(negedge clock);
		end
		if (u_elevator_top.u_elevator_asserts.error_count != 0) begin
			$display("a bound assertion on elevator_top failed");
			$display("Verification failed");
			$fatal(1);
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

// ==== files.f ====
+incdir+logic
logic/elevator_pkg.sv
logic/call_register.sv
logic/travel_scheduler.sv
logic/door_controller.sv
logic/elevator_top.sv
verification/elevator_asserts.sv
verification/elevator_tb.sv

// ==== Bender.yml ====
package:
  name: elevator_controller

sources:
  - include_dirs:
      - logic
    files:
      - logic/elevator_pkg.sv
      - logic/call_register.sv
      - logic/travel_scheduler.sv
      - logic/door_controller.sv
      - logic/elevator_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/elevator_asserts.sv
      - verification/elevator_tb.sv
